//--- emu_link_config.svh
`ifndef EMU_LINK_CONFIG_SVH
`define EMU_LINK_CONFIG_SVH

////////////////////
// emulated time
////////////////////

`define EMU_DT_W 16

// transmit clock half-periods in time units
`define EMU_T_LO 20
`define EMU_T_HI 20

////////////////////
// signal levels
////////////////////

`define EMU_LVL_W 16
`define EMU_TX_MAIN 8000
`define EMU_TX_POST 2000

////////////////////
// step response table
////////////////////

`define EMU_FUNC_W 18
`define EMU_FUNC_ADDR_W 9
// time bits below the table index
`define EMU_FUNC_FRAC_W 4
// 16384 is a gain of one
`define EMU_FUNC_Q 14

`endif

//--- emu_link_pkg.sv
`include "emu_link_config.svh"

package emu_link_pkg;

    ////////////////////
    // vector types
    ////////////////////

    // one step or duration of emulated time
    typedef logic [`EMU_DT_W-1:0] emu_dt_t;

    typedef logic signed [`EMU_LVL_W-1:0] level_t;

    typedef logic signed [`EMU_FUNC_W-1:0] func_word_t;

    typedef logic [`EMU_FUNC_ADDR_W-1:0] func_addr_t;

    // lfsr state and tap mask
    typedef logic [31:0] prbs_word_t;

    ////////////////////
    // channel table
    ////////////////////

    // wdata0 is the segment start, wdata1 the slope per time unit
    typedef struct packed {
        logic       we;
        func_addr_t waddr;
        func_word_t wdata0;
        func_word_t wdata1;
    } chan_wr_t;

    typedef struct packed {
        func_word_t offset;
        func_word_t slope;
    } func_entry_t;

    typedef enum logic {
        PH_LO,
        PH_HI
    } osc_phase_e;

endpackage

//--- osc_model_core.sv
`timescale 1ns/1ps

`include "emu_link_config.svh"

module osc_model_core (
    input  logic                  emu_clk,
    input  logic                  emu_rst,
    input  emu_link_pkg::emu_dt_t dt_max_i,
    output emu_link_pkg::emu_dt_t emu_dt_o,
    output logic                  clk_val_o
);
    import emu_link_pkg::*;

    osc_phase_e phase_q;
    emu_dt_t    t_rem_q;
    logic       edge_now;

    // never step past the next clock edge
    assign emu_dt_o = (t_rem_q < dt_max_i) ? t_rem_q : dt_max_i;

    // this step lands exactly on the edge
    assign edge_now = (emu_dt_o == t_rem_q);

    assign clk_val_o = (phase_q == PH_HI);

    always_ff @(posedge emu_clk) begin
        if (emu_rst) begin
            phase_q <= PH_LO;
            t_rem_q <= emu_dt_t'(`EMU_T_LO);
        end else if (edge_now) begin
            // reload with the half-period of the phase being entered
            if (phase_q == PH_LO) begin
                phase_q <= PH_HI;
                t_rem_q <= emu_dt_t'(`EMU_T_HI);
            end else begin
                phase_q <= PH_LO;
                t_rem_q <= emu_dt_t'(`EMU_T_LO);
            end
        end else begin
            t_rem_q <= t_rem_q - emu_dt_o;
        end
    end

    // a zero step request would freeze emulated time for every block
    dt_max_nonzero_a: assert property (
        @(posedge emu_clk) disable iff (emu_rst)
        dt_max_i != '0
    ) else $error("osc_model_core: dt_max_i is zero");

endmodule

//--- tx_clk_div.sv
`timescale 1ns/1ps

module tx_clk_div (
    input  logic emu_clk,
    input  logic emu_rst,
    input  logic clk_val_i,
    output logic tx_edge_o,
    output logic ext_clk_o
);
    logic clk_val_q;
    logic div_q;

    // first cycle with the clock high after a low cycle
    assign tx_edge_o = clk_val_i & ~clk_val_q;

    // flips in the same cycle as the edge, not one later
    assign ext_clk_o = div_q ^ tx_edge_o;

    always_ff @(posedge emu_clk) begin
        if (emu_rst) begin
            clk_val_q <= 1'b0;
        end else begin
            clk_val_q <= clk_val_i;
        end
    end

    ////////////////////
    // divide by two
    ////////////////////

    always_ff @(posedge emu_clk) begin
        if (emu_rst) begin
            div_q <= 1'b0;
        end else if (tx_edge_o) begin
            div_q <= ~div_q;
        end
    end

endmodule

//--- prbs_gen.sv
`timescale 1ns/1ps

module prbs_gen (
    input  logic                     emu_clk,
    input  logic                     emu_rst,
    input  logic                     cke_i,
    input  emu_link_pkg::prbs_word_t eqn_i,
    output logic                     bit_o
);
    import emu_link_pkg::*;

    prbs_word_t state_q;
    logic       new_bit;

    // fibonacci feedback from the taps picked by the mask
    assign new_bit = ^(state_q & eqn_i);

    always_ff @(posedge emu_clk) begin
        if (emu_rst) begin
            state_q <= prbs_word_t'(1);
        end else if (cke_i) begin
            state_q <= {state_q[30:0], new_bit};
        end
    end

    ////////////////////
    // output bit
    ////////////////////

    always_ff @(posedge emu_clk) begin
        if (emu_rst) begin
            bit_o <= 1'b0;
        end else if (cke_i) begin
            bit_o <= new_bit;
        end
    end

    // a bad tap mask can drain the register, after which the
    // sequence is stuck at zero for good
    state_live_a: assert property (
        @(posedge emu_clk) disable iff (emu_rst)
        state_q != '0
    ) else $error("prbs_gen: lfsr state is all zero, eqn 0x%08h", eqn_i);

endmodule

//--- tx_core.sv
`timescale 1ns/1ps

`include "emu_link_config.svh"

module tx_core (
    input  logic                 emu_clk,
    input  logic                 emu_rst,
    input  logic                 cke_i,
    input  logic                 bit_i,
    output emu_link_pkg::level_t level_o
);
    import emu_link_pkg::*;

    logic   prev_q;
    level_t main_term;
    level_t post_term;

    ////////////////////
    // tap weights
    ////////////////////

    // bit 1 maps to +1 and bit 0 to -1
    always_comb begin
        main_term = bit_i ? level_t'(`EMU_TX_MAIN) : -level_t'(`EMU_TX_MAIN);
        post_term = prev_q ? level_t'(`EMU_TX_POST) : -level_t'(`EMU_TX_POST);
    end

    // de-emphasis by the post-cursor tap
    always_ff @(posedge emu_clk) begin
        if (emu_rst) begin
            prev_q  <= 1'b0;
            level_o <= '0;
        end else if (cke_i) begin
            prev_q  <= bit_i;
            level_o <= main_term - post_term;
        end
    end

endmodule

//--- chan_core.sv
`timescale 1ns/1ps

`include "emu_link_config.svh"

module chan_core (
    input  logic                   emu_clk,
    input  logic                   emu_rst,
    input  logic                   cke_i,
    input  emu_link_pkg::emu_dt_t  dt_i,
    input  emu_link_pkg::level_t   in_i,
    input  emu_link_pkg::chan_wr_t wr_i,
    output emu_link_pkg::level_t   out_o
);
    import emu_link_pkg::*;

    localparam int ELAPSED_W = `EMU_FUNC_ADDR_W + `EMU_FUNC_FRAC_W;
    localparam int FV_W = `EMU_FUNC_W + `EMU_FUNC_FRAC_W + 2;
    localparam int PROD_W = FV_W + `EMU_LVL_W + 1;
    localparam logic [`EMU_DT_W:0] ELAPSED_MAX = (1 << ELAPSED_W) - 1;

    func_entry_t table_q [2**`EMU_FUNC_ADDR_W];
    func_entry_t wr_entry;
    func_entry_t rd_entry;
    func_addr_t  rd_addr;

    logic [ELAPSED_W-1:0] elapsed_q;
    logic [`EMU_DT_W:0]   elapsed_sum;
    level_t               start_q;
    logic signed [`EMU_LVL_W:0] step_q;

    logic signed [FV_W-1:0]   slope_x;
    logic signed [FV_W-1:0]   frac_x;
    logic signed [FV_W-1:0]   func_val;
    logic signed [PROD_W-1:0] prod;

    ////////////////////
    // table storage
    ////////////////////

    // zero table out of configuration
    initial table_q = '{default: '0};

    assign wr_entry = '{offset: wr_i.wdata0, slope: wr_i.wdata1};

    always_ff @(posedge emu_clk) begin
        if (wr_i.we) begin
            table_q[wr_i.waddr] <= wr_entry;
        end
    end

    // upper elapsed bits pick the segment
    assign rd_addr  = func_addr_t'(elapsed_q[ELAPSED_W-1:`EMU_FUNC_FRAC_W]);
    assign rd_entry = table_q[rd_addr];

    ////////////////////
    // step response
    ////////////////////

    // linear within a segment, low elapsed bits are the offset into it
    always_comb begin
        slope_x  = FV_W'(rd_entry.slope);
        frac_x   = FV_W'($signed({1'b0, elapsed_q[`EMU_FUNC_FRAC_W-1:0]}));
        func_val = FV_W'(rd_entry.offset) + slope_x * frac_x;
        prod     = PROD_W'(step_q) * PROD_W'(func_val);
    end

    assign elapsed_sum = (`EMU_DT_W+1)'(elapsed_q) + (`EMU_DT_W+1)'(dt_i);

    always_ff @(posedge emu_clk) begin
        if (emu_rst) begin
            elapsed_q <= '0;
            start_q   <= '0;
            step_q    <= '0;
        end else if (cke_i) begin
            // new transition starts from wherever the output is now
            elapsed_q <= '0;
            start_q   <= out_o;
            step_q    <= (`EMU_LVL_W+1)'(in_i) - (`EMU_LVL_W+1)'(out_o);
        end else if (elapsed_sum > ELAPSED_MAX) begin
            // hold at the last table point
            elapsed_q <= '1;
        end else begin
            elapsed_q <= elapsed_sum[ELAPSED_W-1:0];
        end
    end

    always_ff @(posedge emu_clk) begin
        if (emu_rst) begin
            out_o <= '0;
        end else begin
            out_o <= start_q + level_t'(prod >>> `EMU_FUNC_Q);
        end
    end

    // rewriting the segment in use during a capture corrupts the response
    wr_hazard_a: assert property (
        @(posedge emu_clk) disable iff (emu_rst)
        !(cke_i && wr_i.we && (wr_i.waddr == rd_addr))
    ) else $error("chan_core: write to entry %0d during an edge capture", wr_i.waddr);

endmodule

//--- emu_link_top.sv
`timescale 1ns/1ps

module emu_link_top (
    input  logic                     emu_clk,
    input  logic                     emu_rst,
    input  emu_link_pkg::emu_dt_t    dt_max_i,
    input  emu_link_pkg::prbs_word_t prbs_eqn_i,
    input  emu_link_pkg::chan_wr_t   chan_wr_i,
    output emu_link_pkg::emu_dt_t    emu_dt_o,
    output logic                     tx_edge_o,
    output logic                     ext_clk_o,
    output logic                     tx_bit_o,
    output emu_link_pkg::level_t     tx_level_o,
    output emu_link_pkg::level_t     rx_level_o
);
    logic clk_val;

    ////////////////////
    // transmit clock
    ////////////////////

    osc_model_core osc_model_core_i (
        .emu_clk   (emu_clk),
        .emu_rst   (emu_rst),
        .dt_max_i  (dt_max_i),
        .emu_dt_o  (emu_dt_o),
        .clk_val_o (clk_val)
    );

    // edge pulse and receiver reference clock
    tx_clk_div tx_clk_div_i (
        .emu_clk   (emu_clk),
        .emu_rst   (emu_rst),
        .clk_val_i (clk_val),
        .tx_edge_o (tx_edge_o),
        .ext_clk_o (ext_clk_o)
    );

    ////////////////////
    // data path
    ////////////////////

    prbs_gen prbs_gen_i (
        .emu_clk (emu_clk),
        .emu_rst (emu_rst),
        .cke_i   (tx_edge_o),
        .eqn_i   (prbs_eqn_i),
        .bit_o   (tx_bit_o)
    );

    tx_core tx_core_i (
        .emu_clk (emu_clk),
        .emu_rst (emu_rst),
        .cke_i   (tx_edge_o),
        .bit_i   (tx_bit_o),
        .level_o (tx_level_o)
    );

    // step response advances with the oscillator time step
    chan_core chan_core_i (
        .emu_clk (emu_clk),
        .emu_rst (emu_rst),
        .cke_i   (tx_edge_o),
        .dt_i    (emu_dt_o),
        .in_i    (tx_level_o),
        .wr_i    (chan_wr_i),
        .out_o   (rx_level_o)
    );

endmodule

//--- tb_emu_link.sv
`timescale 1ns/1ps

`include "emu_link_config.svh"

module tb_emu_link;
    import emu_link_pkg::*;

    localparam int PERIOD = `EMU_T_LO + `EMU_T_HI;
    localparam int MAX_REC = 16;
    localparam int ELAPSED_MAX = (1 << (`EMU_FUNC_ADDR_W + `EMU_FUNC_FRAC_W)) - 1;

    // one line of the pattern file
    typedef struct packed {
        int          id;
        int          dt;
        logic [31:0] eqn;
        int          mode;
        int          edges;
        int          chk;
        logic [15:0] bits;
    } rec_t;

    logic       emu_clk;
    logic       emu_rst;
    emu_dt_t    dt_max;
    prbs_word_t prbs_eqn;
    chan_wr_t   chan_wr;
    emu_dt_t    emu_dt;
    logic       tx_edge;
    logic       ext_clk;
    logic       tx_bit;
    level_t     tx_level;
    level_t     rx_level;

    rec_t        recs [MAX_REC];
    int          n_rec;
    func_entry_t tbl [2**`EMU_FUNC_ADDR_W];
    logic [31:0] rng;
    int          err_cnt;
    int          pass_cnt;
    int          fail_cnt;
    int          limit_cycles;
    int          cur_mode;

    ////////////////////
    // reference model state
    ////////////////////

    logic        m_phase;
    int          m_rem;
    logic        m_clk_prev;
    logic        ext_prev;
    prbs_word_t  m_state;
    logic        m_bit;
    logic        m_prev;
    int          m_level;
    int          m_elapsed;
    int          m_start;
    int          m_step;
    int          m_out;
    int          per_sum;
    logic        seen_edge;
    int          edges;
    int          since_edge;
    int          cap_level;
    logic [15:0] got_bits;
    int          n_got;

    emu_link_top emu_link_top_i (
        .emu_clk    (emu_clk),
        .emu_rst    (emu_rst),
        .dt_max_i   (dt_max),
        .prbs_eqn_i (prbs_eqn),
        .chan_wr_i  (chan_wr),
        .emu_dt_o   (emu_dt),
        .tx_edge_o  (tx_edge),
        .ext_clk_o  (ext_clk),
        .tx_bit_o   (tx_bit),
        .tx_level_o (tx_level),
        .rx_level_o (rx_level)
    );

    initial emu_clk = 1'b0;
    always #5 emu_clk = ~emu_clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // random step request between 1 and 24 time units
    function automatic emu_dt_t next_dt_max();
        rng = xorshift32(rng);
        return emu_dt_t'(rng % 24 + 1);
    endfunction

    task automatic report_mismatch(input string name, input longint exp_v, input longint act_v);
        $display("ERROR t=%0t %s expected %0d actual %0d", $time, name, exp_v, act_v);
        err_cnt++;
    endtask

    task automatic read_patterns();
        int          fd;
        int          n;
        int          id;
        int          dt;
        int          mode;
        int          cnt;
        int          chk;
        logic [31:0] eqn;
        logic [15:0] bits;
        string       line;
        n_rec = 0;
        fd = $fopen("emu_link_patterns.txt", "r");
        if (fd == 0) begin
            $display("cannot open emu_link_patterns.txt, no tests run");
            err_cnt++;
        end else begin
            // comment lines do not scan to a full record
            while ($fgets(line, fd) > 0) begin
                n = $sscanf(line, "%d %d %h %d %d %d %h", id, dt, eqn, mode, cnt, chk, bits);
                if (n == 7 && n_rec < MAX_REC) begin
                    recs[n_rec] = '{id, dt, eqn, mode, cnt, chk, bits};
                    n_rec++;
                end
            end
            $fclose(fd);
            if (n_rec == 0) begin
                $display("pattern file holds no test records");
                err_cnt++;
            end
        end
    endtask

    // 0 all zero, 1 unit step, 2 ramp of 64 per time unit
    task automatic load_table(input int mode);
        func_word_t w0;
        func_word_t w1;
        for (int a = 0; a < 2**`EMU_FUNC_ADDR_W; a++) begin
            w0 = (mode == 1) ? func_word_t'(16384) : (mode == 2) ? func_word_t'(a * 1024) : '0;
            w1 = (mode == 2) ? func_word_t'(64) : '0;
            @(posedge emu_clk);
            chan_wr <= '{we: 1'b1, waddr: func_addr_t'(a), wdata0: w0, wdata1: w1};
            tbl[a] = '{offset: w0, slope: w1};
        end
        @(posedge emu_clk);
        chan_wr <= '0;
    endtask

    task automatic reset_model();
        m_phase    = 1'b0;
        m_rem      = `EMU_T_LO;
        m_clk_prev = 1'b0;
        ext_prev   = 1'b0;
        m_state    = prbs_word_t'(1);
        m_bit      = 1'b0;
        m_prev     = 1'b0;
        m_level    = 0;
        m_elapsed  = 0;
        m_start    = 0;
        m_step     = 0;
        m_out      = 0;
        per_sum    = 0;
        seen_edge  = 1'b0;
        edges      = 0;
        since_edge = 0;
        cap_level  = 0;
        got_bits   = '0;
        n_got      = 0;
    endtask

    ////////////////////
    // per-cycle compare
    ////////////////////

    task automatic check_cycle();
        int     exp_dt;
        logic   exp_edge;
        logic   exp_ext;
        logic   nb;
        int     addr;
        longint fval;
        int     nxt_out;
        exp_dt   = (m_rem < int'(dt_max)) ? m_rem : int'(dt_max);
        exp_edge = m_phase & ~m_clk_prev;
        exp_ext  = ext_prev ^ exp_edge;
        if (int'(emu_dt) != exp_dt) begin
            report_mismatch("emu_dt", exp_dt, int'(emu_dt));
        end
        if (tx_edge !== exp_edge) begin
            report_mismatch("tx_edge", exp_edge, tx_edge);
        end
        if (ext_clk !== exp_ext) begin
            report_mismatch("ext_clk", exp_ext, ext_clk);
        end
        if (tx_bit !== m_bit) begin
            report_mismatch("tx_bit", m_bit, tx_bit);
        end
        if (int'(tx_level) != m_level) begin
            report_mismatch("tx_level", m_level, int'(tx_level));
        end
        if (int'(rx_level) != m_out) begin
            report_mismatch("rx_level", m_out, int'(rx_level));
        end
        if (cur_mode == 0 && int'(rx_level) != 0) begin
            report_mismatch("rx_level with zero table", 0, int'(rx_level));
        end
        // unit step settles one cycle after the capture register
        if (cur_mode == 1 && since_edge == 2 && int'(rx_level) != cap_level) begin
            report_mismatch("rx_level after unit step", cap_level, int'(rx_level));
        end
        if (since_edge == 1 && n_got < 16) begin
            got_bits = {got_bits[14:0], tx_bit};
            n_got++;
        end
        // period sum taken from the DUT's own steps and edges
        if (tx_edge === 1'b1) begin
            if (seen_edge && per_sum != PERIOD) begin
                report_mismatch("emu_dt sum over one period", PERIOD, per_sum);
            end
            seen_edge = 1'b1;
            per_sum   = 0;
        end
        per_sum += int'(emu_dt);
        if (exp_edge) begin
            edges++;
            cap_level = m_level;
        end

        // channel output for the next cycle uses this cycle's state
        addr    = m_elapsed >> `EMU_FUNC_FRAC_W;
        fval    = longint'(tbl[addr].offset)
                + longint'(tbl[addr].slope) * (m_elapsed & ((1 << `EMU_FUNC_FRAC_W) - 1));
        nxt_out = int'(level_t'(m_start + ((longint'(m_step) * fval) >>> `EMU_FUNC_Q)));
        if (exp_edge) begin
            m_start    = m_out;
            m_step     = m_level - m_out;
            m_elapsed  = 0;
            m_level    = (m_bit ? `EMU_TX_MAIN : -`EMU_TX_MAIN)
                       - (m_prev ? `EMU_TX_POST : -`EMU_TX_POST);
            m_prev     = m_bit;
            nb         = ^(m_state & prbs_eqn);
            m_state    = {m_state[30:0], nb};
            m_bit      = nb;
            since_edge = 1;
        end else begin
            m_elapsed = (m_elapsed + exp_dt > ELAPSED_MAX) ? ELAPSED_MAX : m_elapsed + exp_dt;
            if (since_edge > 0) begin
                since_edge++;
            end
        end
        m_out      = nxt_out;
        m_clk_prev = m_phase;
        ext_prev   = exp_ext;
        if (exp_dt == m_rem) begin
            m_phase = ~m_phase;
            m_rem   = m_phase ? `EMU_T_HI : `EMU_T_LO;
        end else begin
            m_rem = m_rem - exp_dt;
        end
    endtask

    task automatic run_record(input rec_t r);
        int   errs_before;
        logic rnd;
        errs_before = err_cnt;
        rnd         = (r.dt == 0);
        cur_mode    = r.mode;
        @(posedge emu_clk);
        emu_rst  <= 1'b1;
        dt_max   <= rnd ? emu_dt_t'(5) : emu_dt_t'(r.dt);
        prbs_eqn <= r.eqn;
        load_table(r.mode);
        repeat (4) @(posedge emu_clk);
        emu_rst <= 1'b0;
        if (rnd) begin
            dt_max <= next_dt_max();
        end
        reset_model();
        while (edges < r.edges) begin
            @(negedge emu_clk);
            check_cycle();
            @(posedge emu_clk);
            if (rnd) begin
                dt_max <= next_dt_max();
            end
        end
        if (r.chk != 0 && n_got < 16) begin
            $display("test %0d: only %0d PRBS bits seen, 16 needed", r.id, n_got);
            err_cnt++;
        end else if (r.chk != 0 && got_bits != r.bits) begin
            $display("ERROR t=%0t tx_bit first 16 expected %h actual %h", $time, r.bits, got_bits);
            err_cnt++;
        end
        if (err_cnt == errs_before) begin
            pass_cnt++;
        end else begin
            fail_cnt++;
        end
        $display("test %0d: %s, %0d edges, %0d errors", r.id,
                 (err_cnt == errs_before) ? "ok" : "mismatch", edges, err_cnt - errs_before);
    endtask

    initial begin : main_seq
        int i;
        emu_rst      = 1'b1;
        dt_max       = emu_dt_t'(1);
        prbs_eqn     = '0;
        chan_wr      = '0;
        rng          = 32'hf0fa;
        err_cnt      = 0;
        pass_cnt     = 0;
        fail_cnt     = 0;
        cur_mode     = 0;
        limit_cycles = 0;
        read_patterns();
        for (i = 0; i < n_rec; i++) begin
            limit_cycles += recs[i].edges * 2 * PERIOD + 600;
        end
        limit_cycles += 2000;
        for (i = 0; i < n_rec; i++) begin
            run_record(recs[i]);
        end
        $display("summary: %0d tests ok, %0d tests with errors, %0d errors total",
                 pass_cnt, fail_cnt, err_cnt);
        if (err_cnt == 0 && fail_cnt == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

    initial begin : watchdog
        wait (limit_cycles > 0);
        repeat (limit_cycles) @(posedge emu_clk);
        $display("watchdog: run did not end within %0d emu_clk cycles", limit_cycles);
        $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

//--- emu_link_patterns.txt
# columns: id, dt_max (0 means random per cycle), prbs_eqn (hex), table mode
# (0 zero, 1 unit step, 2 ramp), edges, compare bits flag, first 16 bits (hex, first in msb)
1 7 00000060 1 20 1 0614
2 40 00000060 0 20 1 0614
3 0 48000000 2 30 1 0000
4 0 00000060 1 30 1 0614
5 3 48000000 2 40 0 0000
6 1 00000060 2 12 0 0000
7 20 48000000 0 24 1 0000
8 0 00000060 2 40 1 0614

//--- emu_link_top.f
+incdir+.
emu_link_pkg.sv
osc_model_core.sv
tx_clk_div.sv
prbs_gen.sv
tx_core.sv
chan_core.sv
emu_link_top.sv
tb_emu_link.sv

//--- Makefile
TOP := tb_emu_link

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) \
		-f emu_link_top.f -o sim_emu_link

run: compile
	./obj_dir/sim_emu_link | tee sim.log
	@if grep -q "Simulation finished: FAIL" sim.log; then exit 1; fi
	@grep -q "Simulation finished: PASS" sim.log

clean:
	rm -rf obj_dir sim.log
